/* hw/cpu_pkg.sv */
/*
 * Shared widths, microword layout, enums and status layout for the 8-bit
 * microprogrammed CPU. RTL modules import it inside their bodies and use
 * scoped names for port types.
 */
package cpu_pkg;

	localparam int data_w     = 8;  // Data and address width
	localparam int uword_w    = 24; // Control store word width
	localparam int n_regs     = 8;  // Registers on the internal bus
	localparam int fetch_addr = 3;  // Fetch microroutine entry
	localparam int irq_addr   = 7;  // Interrupt microroutine entry

	typedef enum logic [2:0] {
		PC  = 3'd0,
		IR  = 3'd1,
		MAR = 3'd2,
		MDR = 3'd3,
		ACC = 3'd4,
		ANS = 3'd5,
		R1  = 3'd6,
		R0  = 3'd7
	} reg_idx_e;

	typedef enum logic [2:0] {
		ADD    = 3'b000,
		SUB    = 3'b001,
		PASS_A = 3'b010, // Multiply slot in older decks
		NOT_B  = 3'b011,
		XOR    = 3'b100,
		INC_B  = 3'b101,
		PASS_B = 3'b110, // Divide slot in older decks
		NONE   = 3'b111
	} alu_op_e;

	typedef enum logic [2:0] {
		GO_FETCH  = 3'b000,
		MAP       = 3'b001,
		JUMP      = 3'b010,
		BRANCH_Z  = 3'b011,
		NEXT      = 3'b100,
		IRQ_CHECK = 3'b101,
		HOLD      = 3'b110,
		HOLD_ALT  = 3'b111 // Second encoding of hold
	} seq_mode_e;

	typedef struct packed {
		alu_op_e    alu_op;    // [23:21]
		logic [2:0] sel_hi;    // [20:18] Also jump target high bits
		logic [1:0] rw_hi;     // [17:16] Write, read
		logic [2:0] sel_lo;    // [15:13]
		logic [1:0] rw_lo;     // [12:11] Write, read
		logic [1:0] io;        // [10:9] 01 IN, 10 OUT
		logic       pc_inc;    // [8]
		logic [1:0] flag_mode; // [7:6]
		logic       addr_sel;  // [5] 1 MAR, 0 PC
		logic       ram_wr;    // [4]
		logic       ram_rd;    // [3]
		seq_mode_e  seq;       // [2:0]
	} micro_word_t;

	typedef struct packed {
		logic [n_regs-1:0] rd; // One-hot by reg_idx_e
		logic [n_regs-1:0] wr;
	} bus_en_t;

	typedef struct packed {
		logic [2:0] rsvd_hi; // Always 0
		logic       ovf_neg;
		logic       ovf_pos;
		logic       zero;
		logic       rsvd_lo; // Always 0
		logic       carry;
	} status_t;

endpackage

/* hw/bus_ctrl.sv */
/*
 * Microword field decoder. Turns the two select/rw pairs into one-hot
 * register read and write enables and derives the IN and OUT strobes.
 */
`timescale 1ns/100ps

module bus_ctrl (
	input  cpu_pkg::micro_word_t uword,
	output cpu_pkg::bus_en_t     bus_en,
	output logic                 in_sel,
	output logic                 out_load
);
	import cpu_pkg::*;

	// One-hot decode of a select field, empty when not enabled
	function automatic logic [n_regs-1:0] dec_sel(input logic [2:0] sel, input logic en);
		logic [n_regs-1:0] v;
		v = '0;
		if (en)
			v[sel] = 1'b1;
		return v;
	endfunction

	always_comb begin
		bus_en.rd = dec_sel(uword.sel_lo, uword.rw_lo[0]) |
			dec_sel(uword.sel_hi, uword.rw_hi[0]); // Both halves may drive
		bus_en.wr = dec_sel(uword.sel_lo, uword.rw_lo[1]) |
			dec_sel(uword.sel_hi, uword.rw_hi[1]);
	end

	assign in_sel   = (uword.io == 2'b01); // Keyboard onto bus
	assign out_load = (uword.io == 2'b10); // Bus into output port

	// Two halves of one microword must not read different registers
	always_comb begin
		a_one_reader: assert final (in_sel || $onehot0(bus_en.rd))
			else $error("bus_ctrl: more than one register read %b", bus_en.rd);
	end

endmodule

/* hw/opcode_map.sv */
/*
 * Opcode to microroutine entry table. Driven from IR and read by the
 * micro-sequencer in MAP mode; opcodes not listed dispatch to 0.
 */
`timescale 1ns/100ps

module opcode_map (
	input  logic [cpu_pkg::data_w-1:0] opcode,
	output logic [cpu_pkg::data_w-1:0] entry
);
	import cpu_pkg::*;

	always_comb begin
		case (opcode)
			8'h80:   entry = 8'd0;   // GETPC
			8'h81:   entry = 8'd3;   // GETMAR
			8'h82:   entry = 8'd7;   // CH_INTERRUPT
			8'h83:   entry = 8'd8;   // JUMP_E
			8'h84:   entry = 8'd9;   // JUMP_N
			8'h00:   entry = 8'd10;  // LOAD_MAR_R0
			8'h01:   entry = 8'd13;  // LOAD_MAR_R1
			8'h04:   entry = 8'd22;  // LOAD_PC_R0
			8'h08:   entry = 8'd42;  // LOAD_NUM_R0
			8'h10:   entry = 8'd54;  // STORE_MAR_R0
			8'h14:   entry = 8'd66;  // STORE_PC_R0
			8'h22:   entry = 8'd98;  // R0 to R1
			8'h26:   entry = 8'd106; // R1 to R0
			8'h30:   entry = 8'd118; // ALU add R0
			8'h32:   entry = 8'd120; // ALU sub R0
			8'h34:   entry = 8'd122; // ALU xor R0
			8'h74:   entry = 8'd159; // IN_R0
			8'h78:   entry = 8'd167; // OUT_R0
			8'h7A:   entry = 8'd173; // OUT_ANS
			8'hF0:   entry = 8'd146; // Halt loop
			default: entry = '0;     // Unmapped back to start
		endcase
	end

endmodule

/* hw/micro_seq.sv */
/*
 * Micro-sequencer. Holds the micro-PC that addresses the external control
 * store and picks the next address from the seq field of the microword.
 * Advances only on clock edges with run high.
 */
`timescale 1ns/100ps

module micro_seq (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       run,
	input  cpu_pkg::seq_mode_e         seq,
	input  logic [cpu_pkg::data_w-1:0] jump_target,
	input  logic [cpu_pkg::data_w-1:0] map_entry,
	input  logic                       zero,
	input  logic                       interrupt,
	output logic [cpu_pkg::data_w-1:0] rom_addr
);
	import cpu_pkg::*;

	logic [data_w-1:0] upc; // Micro-PC
	logic [data_w-1:0] upc_nxt;

	always_comb begin
		case (seq)
			NEXT:      upc_nxt = upc + 1'b1;
			MAP:       upc_nxt = map_entry;   // Dispatch on IR
			JUMP:      upc_nxt = jump_target;
			GO_FETCH:  upc_nxt = data_w'(fetch_addr);
			BRANCH_Z: begin
				if (zero)
					upc_nxt = '0;                 // Result was zero
				else
					upc_nxt = data_w'(fetch_addr);
			end
			IRQ_CHECK: begin
				if (interrupt)
					upc_nxt = data_w'(irq_addr);
				else
					upc_nxt = '0;
			end
			HOLD, HOLD_ALT: upc_nxt = upc;
			default:   upc_nxt = upc;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst)
			upc <= '0;
		else if (run)
			upc <= upc_nxt; // Stalled otherwise
	end

	assign rom_addr = upc;

	// Control store address must stay defined once out of reset
	a_addr_known: assert property (@(posedge clk) disable iff (!rst)
		!$isunknown(rom_addr))
		else $error("micro_seq: rom_addr unknown");

endmodule

/* hw/alu.sv */
/*
 * Combinational ALU. Operand a is the accumulator and b the internal bus.
 * Produces the result for ANS plus raw carry and signed overflow, which
 * the status register decides whether to keep.
 */
`timescale 1ns/100ps

module alu (
	input  cpu_pkg::alu_op_e           op,
	input  logic [cpu_pkg::data_w-1:0] a,
	input  logic [cpu_pkg::data_w-1:0] b,
	input  logic                       carry_in,
	input  logic [1:0]                 flag_mode,
	output logic [cpu_pkg::data_w-1:0] result,
	output logic                       carry,
	output logic                       ovf_pos,
	output logic                       ovf_neg
);
	import cpu_pkg::*;

	logic [data_w:0] sum; // Extra bit for carry out
	logic            cin_eff;

	always_comb begin
		cin_eff = flag_mode[1] & carry_in; // Modes 10 and 11 add stored carry
		sum     = '0;
		result  = '0;
		carry   = 1'b0;
		ovf_pos = 1'b0;
		ovf_neg = 1'b0;
		case (op)
			ADD: begin
				sum     = {1'b0, a} + {1'b0, b} + cin_eff;
				result  = sum[data_w-1:0];
				carry   = sum[data_w];
				ovf_pos = ~a[data_w-1] & ~b[data_w-1] & result[data_w-1]; // Pos plus pos
				ovf_neg = a[data_w-1] & b[data_w-1] & ~result[data_w-1];
			end
			SUB: begin
				sum     = {1'b0, a} + {1'b0, ~b} + 1'b1; // Two's complement
				result  = sum[data_w-1:0];
				carry   = sum[data_w];                   // Set when no borrow
				ovf_pos = ~a[data_w-1] & b[data_w-1] & result[data_w-1];
				ovf_neg = a[data_w-1] & ~b[data_w-1] & ~result[data_w-1];
			end
			PASS_A:  result = a;
			NOT_B:   result = ~b;
			XOR:     result = a ^ b;
			INC_B:   result = b + 1'b1; // PC style increment
			PASS_B:  result = b;
			default: result = '0;       // NONE
		endcase
	end

endmodule

/* hw/status_flags.sv */
/*
 * Status register beside the ALU. Keeps carry, zero and the two signed
 * overflow bits according to the ALU op and flag mode; its carry bit feeds
 * back into the ALU and zero steers BRANCH_Z.
 */
`timescale 1ns/100ps

module status_flags (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       run,
	input  cpu_pkg::alu_op_e           op,
	input  logic [1:0]                 flag_mode,
	input  logic                       carry,
	input  logic                       ovf_pos,
	input  logic                       ovf_neg,
	input  logic [cpu_pkg::data_w-1:0] result,
	output cpu_pkg::status_t           status
);
	import cpu_pkg::*;

	logic keep_ovf;

	assign keep_ovf = (op == SUB) || (op == ADD && flag_mode == 2'b00);

	always_ff @(posedge clk) begin
		if (!rst) begin
			status <= '0;
		end else if (run && op != NONE) begin
			status.zero <= (result == '0);
			if (op == ADD && flag_mode[0])
				status.carry <= carry; // Record modes 01 and 11
			status.ovf_pos <= keep_ovf & ovf_pos; // Cleared by other ops
			status.ovf_neg <= keep_ovf & ovf_neg;
		end
	end

endmodule

/* hw/reg_bank.sv */
/*
 * The eight bus registers, the internal bus multiplexer and the I/O side.
 * Bus source is the keyboard on IN, else the lowest enabled register.
 * Provides ACC and IR taps, the RAM address and write data, and the
 * output port register.
 */
`timescale 1ns/100ps

module reg_bank (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       run,
	input  cpu_pkg::bus_en_t           bus_en,
	input  logic                       in_sel,
	input  logic                       out_load,
	input  logic                       pc_inc,
	input  logic                       addr_sel,
	input  logic [cpu_pkg::data_w-1:0] alu_result,
	input  logic [cpu_pkg::data_w-1:0] keyboard,
	input  logic [cpu_pkg::data_w-1:0] ram_rdata,
	input  logic                       ram_rd,
	output logic [cpu_pkg::data_w-1:0] acc,
	output logic [cpu_pkg::data_w-1:0] bus,
	output logic [cpu_pkg::data_w-1:0] ir,
	output logic [cpu_pkg::data_w-1:0] ram_addr,
	output logic [cpu_pkg::data_w-1:0] ram_wdata,
	output logic [cpu_pkg::data_w-1:0] out_port
);
	import cpu_pkg::*;

	logic [data_w-1:0] regs [n_regs]; // Indexed by reg_idx_e

	// Priority mux; scanning downward leaves the lowest index
	always_comb begin
		bus = '0;
		if (in_sel) begin
			bus = keyboard;
		end else begin
			for (int i = n_regs - 1; i >= 0; i--) begin
				if (bus_en.rd[i])
					bus = regs[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < n_regs; i++)
				regs[i] <= '0;
			out_port <= '0;
		end else if (run) begin
			for (int i = 0; i < n_regs; i++) begin
				if (bus_en.wr[i])
					regs[i] <= bus; // Plain bus load
			end
			// Later assignments override the bus load
			if (bus_en.wr[ANS])
				regs[ANS] <= alu_result;
			if (ram_rd)
				regs[MDR] <= ram_rdata;
			if (pc_inc)
				regs[PC] <= regs[PC] + 1'b1; // Wins over bus write
			if (out_load)
				out_port <= bus;
		end
	end

	assign acc       = regs[ACC];
	assign ir        = regs[IR];
	assign ram_addr  = addr_sel ? regs[MAR] : regs[PC];
	assign ram_wdata = regs[MDR];

endmodule

/* hw/cpu_top.sv */
/*
 * CPU datapath top level. Takes one microword per cycle from an external
 * control store addressed by rom_addr and connects the decoder, sequencer,
 * ALU, status register and register bank. RAM strobes follow the microword.
 */
`timescale 1ns/100ps

module cpu_top (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       run,
	input  cpu_pkg::micro_word_t       uword,
	input  logic [cpu_pkg::data_w-1:0] keyboard,
	input  logic                       interrupt,
	input  logic [cpu_pkg::data_w-1:0] ram_rdata,
	output logic [cpu_pkg::data_w-1:0] rom_addr,
	output logic [cpu_pkg::data_w-1:0] ram_addr,
	output logic [cpu_pkg::data_w-1:0] ram_wdata,
	output logic                       ram_we,
	output logic                       ram_re,
	output logic [cpu_pkg::data_w-1:0] out_port
);
	import cpu_pkg::*;

	bus_en_t           bus_en;
	logic              in_sel;
	logic              out_load;
	logic [data_w-1:0] acc;
	logic [data_w-1:0] bus;
	logic [data_w-1:0] ir;
	logic [data_w-1:0] alu_result;
	logic              alu_carry;
	logic              ovf_pos;
	logic              ovf_neg;
	status_t           status;
	logic [data_w-1:0] map_entry;

	assign ram_we = uword.ram_wr & run; // No strobes while stalled
	assign ram_re = uword.ram_rd & run;

	bus_ctrl u_bus_ctrl (.uword(uword), .bus_en(bus_en), .in_sel(in_sel), .out_load(out_load));

	opcode_map u_opcode_map (.opcode(ir), .entry(map_entry));

	micro_seq u_micro_seq (
		.clk(clk), .rst(rst), .run(run), .seq(uword.seq),
		.jump_target({uword.sel_hi, uword.rw_hi, uword.sel_lo}), // 8-bit target
		.map_entry(map_entry), .zero(status.zero), .interrupt(interrupt),
		.rom_addr(rom_addr)
	);

	alu u_alu (
		.op(uword.alu_op), .a(acc), .b(bus), .carry_in(status.carry),
		.flag_mode(uword.flag_mode), .result(alu_result), .carry(alu_carry),
		.ovf_pos(ovf_pos), .ovf_neg(ovf_neg)
	);

	status_flags u_status_flags (
		.clk(clk), .rst(rst), .run(run), .op(uword.alu_op), .flag_mode(uword.flag_mode),
		.carry(alu_carry), .ovf_pos(ovf_pos), .ovf_neg(ovf_neg), .result(alu_result),
		.status(status)
	);

	reg_bank u_reg_bank (
		.clk(clk), .rst(rst), .run(run), .bus_en(bus_en), .in_sel(in_sel),
		.out_load(out_load), .pc_inc(uword.pc_inc), .addr_sel(uword.addr_sel),
		.alu_result(alu_result), .keyboard(keyboard), .ram_rdata(ram_rdata),
		.ram_rd(ram_re), .acc(acc), .bus(bus), .ir(ir), .ram_addr(ram_addr),
		.ram_wdata(ram_wdata), .out_port(out_port)
	);

	// RAM port is single direction per cycle
	a_ram_rw_excl: assert property (@(posedge clk) disable iff (!rst)
		!(ram_we && ram_re))
		else $error("cpu_top: ram_we and ram_re both set");

endmodule

/* sim/tb_clock.sv */
/*
 * Free-running testbench clock, 4 ns period, starting low.
 */
`timescale 1ns/100ps

module tb_clock (
	output logic clk
);
	localparam real half_period = 2.0; // ns

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

endmodule

/* sim/tb_checker.sv */
/*
 * Result checker. On each rising edge with a stim line active it compares
 * the DUT outputs against that line's expected values, keeps per-group and
 * total counts, and prints one summary line as each test group ends.
 * Vector layout is {rom_addr, out_port, ram_addr, ram_wdata, ram_we, ram_re}.
 */
`timescale 1ns/100ps

module tb_checker (
	input  logic        clk,
	input  logic        active,  // Expected values valid this cycle
	input  logic        done,    // Stim exhausted
	input  logic [3:0]  group,
	input  logic [33:0] exp_vec,
	input  logic [33:0] act_vec,
	output int          n_checks,
	output int          n_errs
);
	int         grp_checks;
	int         grp_errs;
	logic [3:0] cur_group;
	logic       closed;

	initial begin
		n_checks   = 0;
		n_errs     = 0;
		grp_checks = 0;
		grp_errs   = 0;
		cur_group  = 4'd0; // No group open yet
		closed     = 1'b0;
	end

	function automatic string group_name(input logic [3:0] g);
		case (g)
			4'd1:    return "reset and sequencing";
			4'd2:    return "opcode dispatch";
			4'd3:    return "register moves and output";
			4'd4:    return "alu and flags";
			4'd5:    return "ram port";
			4'd6:    return "stall and interrupt";
			default: return "unnamed group";
		endcase
	endfunction

	task automatic report_group();
		$display("test %0d %s: %0d checks, %0d errors", cur_group,
			group_name(cur_group), grp_checks, grp_errs);
	endtask

	// One field compare, 1-bit fields zero extended
	task automatic compare_value(input string name, input logic [7:0] exp,
		input logic [7:0] act);
		n_checks++;
		grp_checks++;
		if (act !== exp) begin
			n_errs++;
			grp_errs++;
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	always @(posedge clk) begin
		if (active) begin
			if (group !== cur_group) begin
				if (cur_group != 4'd0)
					report_group(); // Previous group finished
				cur_group  = group;
				grp_checks = 0;
				grp_errs   = 0;
			end
			compare_value("rom_addr", exp_vec[33:26], act_vec[33:26]);
			compare_value("out_port", exp_vec[25:18], act_vec[25:18]);
			compare_value("ram_addr", exp_vec[17:10], act_vec[17:10]);
			compare_value("ram_wdata", exp_vec[9:2], act_vec[9:2]);
			compare_value("ram_we", {7'd0, exp_vec[1]}, {7'd0, act_vec[1]});
			compare_value("ram_re", {7'd0, exp_vec[0]}, {7'd0, act_vec[0]});
			if (act_vec[1] && act_vec[0]) begin
				n_errs++;
				grp_errs++;
				$display("Error at %0t: RAM write and read strobes are set together", $time);
			end
		end else if (done && !closed) begin
			if (cur_group != 4'd0)
				report_group(); // Last group
			closed = 1'b1;
		end
	end

endmodule

/* sim/tb_top.sv */
/*
 * Testbench top. Replays sim/cpu_stim.txt one line per cycle into the CPU,
 * standing in for the control store, keyboard, interrupt line and RAM,
 * and hands each line's expected outputs to the checker.
 * Inputs change on the falling edge; a group 0 line ends the stim.
 */
`timescale 1ns/100ps

module tb_top;
	import cpu_pkg::*;

	localparam int max_lines    = 128;
	localparam int reset_cycles = 4;

	logic [91:0] stim [max_lines]; // See column list in the stim file
	logic        clk;
	logic        rst;
	logic        run;
	micro_word_t uword;
	logic [7:0]  keyboard;
	logic        interrupt;
	logic [7:0]  ram_rdata;
	logic [7:0]  rom_addr;
	logic [7:0]  ram_addr;
	logic [7:0]  ram_wdata;
	logic        ram_we;
	logic        ram_re;
	logic [7:0]  out_port;
	logic [3:0]  group;
	logic        active;
	logic        done;
	logic [33:0] exp_vec;
	logic [33:0] act_vec;
	int          n_lines;
	int          n_checks;
	int          n_errs;
	int          limit  = 0;
	int          cycles = 0;

	tb_clock u_clock (.clk(clk));

	cpu_top uut (
		.clk(clk), .rst(rst), .run(run), .uword(uword), .keyboard(keyboard),
		.interrupt(interrupt), .ram_rdata(ram_rdata), .rom_addr(rom_addr),
		.ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we),
		.ram_re(ram_re), .out_port(out_port)
	);

	assign act_vec = {rom_addr, out_port, ram_addr, ram_wdata, ram_we, ram_re};

	tb_checker u_checker (
		.clk(clk), .active(active), .done(done), .group(group),
		.exp_vec(exp_vec), .act_vec(act_vec), .n_checks(n_checks), .n_errs(n_errs)
	);

	// Split one stim word into DUT inputs and expected outputs
	task automatic apply_line(input logic [91:0] v);
		group     = v[91:88];
		uword     = v[87:64];
		keyboard  = v[63:56];
		interrupt = v[52];
		ram_rdata = v[51:44];
		run       = v[40];
		exp_vec   = {v[39:8], v[4], v[0]};
		active    = 1'b1;
	endtask

	// Cycle limit set once the stim length is known
	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout: stim not finished after %0d cycles", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	initial begin
		rst       = 1'b0;
		run       = 1'b0;
		uword     = '0;
		keyboard  = '0;
		interrupt = 1'b0;
		ram_rdata = '0;
		group     = '0;
		active    = 1'b0;
		done      = 1'b0;
		exp_vec   = '0;
		$readmemh("sim/cpu_stim.txt", stim);
		n_lines = 0;
		while (n_lines < max_lines && stim[n_lines][91:88] != 4'h0)
			n_lines++;
		limit = 2 * n_lines + 20;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b1; // Release away from the active edge
		for (int i = 0; i < n_lines; i++) begin
			apply_line(stim[i]);
			@(negedge clk);
		end
		active = 1'b0;
		run    = 1'b0;
		done   = 1'b1;
		@(posedge clk);
		#1;
		$display("%0d checks, %0d errors, %0d stim lines", n_checks, n_errs, n_lines);
		if (n_errs == 0 && n_checks > 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* sim/cpu_stim.txt */
// grp_uword_keyboard_irq_rdata_run _ exp: rom_addr_out_port_ram_addr_ram_wdata_we_re
// One line per cycle, grp 0 ends the list
1_e00004_00_0_00_1_00_00_00_00_0_0
1_e00004_00_0_00_1_01_00_00_00_0_0
1_e80002_00_0_00_1_02_00_00_00_0_0
1_e00006_00_0_00_1_40_00_00_00_0_0
1_e00000_00_0_00_1_40_00_00_00_0_0
2_e0000c_00_0_30_1_03_00_00_00_0_1
2_e66804_00_0_00_1_04_00_00_30_0_0
2_e00001_00_0_00_1_05_00_00_30_0_0
2_e0000c_00_0_55_1_76_00_00_30_0_1
2_e66804_00_0_00_1_77_00_00_55_0_0
2_e00001_00_0_00_1_78_00_00_55_0_0
3_e0f204_a5_0_00_1_00_00_00_55_0_0
3_fae804_00_0_00_1_01_00_00_55_0_0
3_e0cc04_00_0_00_1_02_00_00_55_0_0
3_e00004_00_0_00_1_03_a5_00_55_0_0
4_e09204_5b_0_00_1_04_a5_00_55_0_0
4_16e844_00_0_00_1_05_a5_00_55_0_0
4_e00003_00_0_00_1_06_a5_00_55_0_0
4_16e884_00_0_00_1_00_a5_00_55_0_0
4_e0ac04_00_0_00_1_01_a5_00_55_0_0
4_e00003_00_0_00_1_02_01_00_55_0_0
4_368804_00_0_00_1_03_01_00_55_0_0
4_e00003_00_0_00_1_04_01_00_55_0_0
5_e05204_3c_0_00_1_00_01_00_55_0_0
5_e00024_00_0_00_1_01_01_3c_55_0_0
5_e00104_00_0_00_1_02_01_00_55_0_0
5_e2e904_00_0_00_1_03_01_01_55_0_0
5_eec804_00_0_00_1_04_01_02_55_0_0
5_e00034_00_0_00_1_05_01_3c_a5_1_0
5_e0000c_00_0_99_1_06_01_02_a5_0_1
6_e0ec0c_00_0_00_0_07_01_02_99_0_0
6_e80112_00_0_00_0_07_01_02_99_0_0
6_e00005_00_0_00_1_07_01_02_99_0_0
6_e00005_00_1_00_1_00_01_02_99_0_0
6_e00004_00_0_00_1_07_01_02_99_0_0
0_000000_00_0_00_0_00_00_00_00_0_0

/* compile.f */
hw/cpu_pkg.sv
hw/bus_ctrl.sv
hw/opcode_map.sv
hw/micro_seq.sv
hw/alu.sv
hw/status_flags.sv
hw/reg_bank.sv
hw/cpu_top.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_top.sv
